// ==== Makefile ====
# Verilator build and run of the SIMD memory bridge testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       ?= simdMemBridgeTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
PASS_MSG  := Test OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

// ==== hdl/dmemPort.sv ====
/*
  One lane's data-memory port. Forms the RAM word address and valid strobe,
  captures opcode and byte offset on each load and right-aligns the returned
  word one cycle later. Used for the CP lane and for every PE lane.
*/
`timescale 1ns/1ps
`default_nettype none

module dmemPort import memBridgePkg::*; #(
  parameter int RAM_ADDR_BITS = 10          // word address width of the RAM
) (
  input  wire logic                     iClk,
  input  wire logic                     rstN,
  input  wire dmemReqT                  req,           // lane request from core
  input  wire logic                     overrideEn,    // replace load result
  input  wire logic [DATA_WIDTH-1:0]    overrideData,
  output logic                          dmemValid,
  output logic                          dmemWriteEnable,
  output logic                          dmemReadEnable,
  output logic [RAM_ADDR_BITS-1:0]      dmemAddr,
  output logic [BYTE_LANES-1:0]         dmemByteSelect,
  output logic [DATA_WIDTH-1:0]         dmemWriteData,
  input  wire logic [DATA_WIDTH-1:0]    dmemReadData,  // one cycle after read
  output logic [DATA_WIDTH-1:0]         loadData       // aligned, zero-extended
);

  cpAddrU                  addrView;    // byte address split into word and offset
  lsuOpT                   opcodeQ;     // opcode of the load in flight
  logic [1:0]              offsetQ;     // byte offset of the load in flight
  logic [DATA_WIDTH-1:0]   alignedData;

  // ==============================
  // request side
  // ==============================
  assign addrView        = req.byteAddr;
  assign dmemAddr        = addrView.mem.word[RAM_ADDR_BITS-1:0]; // byte addr >> 2, truncated
  assign dmemWriteEnable = req.writeEnable;
  assign dmemReadEnable  = req.readEnable;
  assign dmemValid       = req.writeEnable | req.readEnable;
  assign dmemByteSelect  = req.byteSelect;  // unchanged
  assign dmemWriteData   = req.storeData;   // unchanged

  // load info, only moves on a read so each load keeps its own
  always_ff @(posedge iClk or negedge rstN) begin
    if (!rstN) begin
      opcodeQ <= LSU_WORD;
      offsetQ <= 2'b00;
    end else if (req.readEnable) begin
      opcodeQ <= req.opcode;
      offsetQ <= addrView.mem.offset;
    end
  end

  // ==============================
  // response side
  // ==============================
  always_comb begin
    case (opcodeQ)
      LSU_WORD: alignedData = dmemReadData;
      LSU_HALF: begin
        if (offsetQ[1]) begin
          alignedData = {16'b0, dmemReadData[31:16]}; // upper half
        end else begin
          alignedData = {16'b0, dmemReadData[15:0]};  // lower half
        end
      end
      LSU_BYTE: begin
        case (offsetQ)
          2'b00:   alignedData = {24'b0, dmemReadData[7:0]};
          2'b01:   alignedData = {24'b0, dmemReadData[15:8]};
          2'b10:   alignedData = {24'b0, dmemReadData[23:16]};
          default: alignedData = {24'b0, dmemReadData[31:24]};
        endcase
      end
      default:  alignedData = dmemReadData;    // unused code, treat as word
    endcase
  end

  // special read data wins over memory
  assign loadData = overrideEn ? overrideData : alignedData;

endmodule

`default_nettype wire

// ==== hdl/memBridgePkg.sv ====
/*
  Shared types and constants for the SIMD data-memory bridge.
  Imported by every bridge module and by the testbench.
*/
`default_nettype none

package memBridgePkg;

  // ==============================
  // widths
  // ==============================
  parameter int DATA_WIDTH = 32;             // data and byte-address width, alignment assumes 32
  parameter int BYTE_LANES = DATA_WIDTH / 8; // byte-select width

  // load/store access width
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } lsuOpT;

  // how the edge PEs treat a missing neighbour
  typedef enum logic [1:0] {
    BOUNDARY_ZERO   = 2'b00, // reset value, neighbour reads as zero
    BOUNDARY_WRAP   = 2'b01, // wrap around to the other edge
    BOUNDARY_SELF   = 2'b10, // reuse own value
    BOUNDARY_SCALAR = 2'b11  // take the CP value
  } boundaryModeT;

  // register offsets inside the special page 0xFFFF_FF00..0xFFFF_FFFF
  parameter logic [7:0] BOUNDARY_FIRST_OFFSET = 8'h00;
  parameter logic [7:0] BOUNDARY_LAST_OFFSET  = 8'h04;

  // ==============================
  // lane request from the core
  // ==============================
  typedef struct packed {
    logic                    writeEnable;
    logic                    readEnable;
    lsuOpT                   opcode;     // word / half / byte
    logic [DATA_WIDTH-1:0]   byteAddr;   // core byte address
    logic [BYTE_LANES-1:0]   byteSelect; // passed through to memory
    logic [DATA_WIDTH-1:0]   storeData;  // passed through to memory
  } dmemReqT;

  // byte address seen as memory access or as special-page access
  typedef union packed {
    struct packed {
      logic [DATA_WIDTH-3:0] word;       // word index
      logic [1:0]            offset;     // byte inside the word
    } mem;
    struct packed {
      logic [23:0]           page;       // all ones selects the special page
      logic [7:0]            regOffset;  // register inside the page
    } special;
  } cpAddrU;

endpackage

`default_nettype wire

// ==== hdl/simdMemBridge.sv ====
/*
  Data-memory bridge of the SIMD core. One CP lane with special-page decode
  and NUM_PE PE lanes, each with its own synchronous data memory.
*/
`timescale 1ns/1ps
`default_nettype none

module simdMemBridge import memBridgePkg::*; #(
  parameter int NUM_PE        = 4,   // PE lanes
  parameter int RAM_ADDR_BITS = 10   // word address width of every RAM
) (
  input  wire logic                   iClk,
  input  wire logic                   rstN,

  // CP lane
  input  wire dmemReqT                cpReq,
  output logic                        cpDmemValid,
  output logic                        cpDmemWriteEnable,
  output logic                        cpDmemReadEnable,
  output logic [RAM_ADDR_BITS-1:0]    cpDmemAddr,
  output logic [BYTE_LANES-1:0]       cpDmemByteSelect,
  output logic [DATA_WIDTH-1:0]       cpDmemWriteData,
  input  wire logic [DATA_WIDTH-1:0]  cpDmemReadData,
  output logic [DATA_WIDTH-1:0]       cpLoadData,

  // PE lanes
  input  wire dmemReqT                peReq            [NUM_PE],
  output logic                        peDmemValid      [NUM_PE],
  output logic                        peDmemWriteEnable[NUM_PE],
  output logic                        peDmemReadEnable [NUM_PE],
  output logic [RAM_ADDR_BITS-1:0]    peDmemAddr       [NUM_PE],
  output logic [BYTE_LANES-1:0]       peDmemByteSelect [NUM_PE],
  output logic [DATA_WIDTH-1:0]       peDmemWriteData  [NUM_PE],
  input  wire logic [DATA_WIDTH-1:0]  peDmemReadData   [NUM_PE],
  output logic [DATA_WIDTH-1:0]       peLoadData       [NUM_PE],

  // to the PE array
  output boundaryModeT                boundaryModeFirst,
  output boundaryModeT                boundaryModeLast
);

  dmemReqT                 cpGatedReq;     // CP request with page writes removed
  logic                    specialRdSel;
  logic [DATA_WIDTH-1:0]   specialRdData;

  // ==============================
  // CP lane
  // ==============================
  specialRegCtrl u_specialRegCtrl (
    .iClk              (iClk),
    .rstN              (rstN),
    .cpReq             (cpReq),
    .gatedReq          (cpGatedReq),
    .specialRdSel      (specialRdSel),
    .specialRdData     (specialRdData),
    .boundaryModeFirst (boundaryModeFirst),
    .boundaryModeLast  (boundaryModeLast)
  );

  dmemPort #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_cpPort (
    .iClk            (iClk),
    .rstN            (rstN),
    .req             (cpGatedReq),
    .overrideEn      (specialRdSel),  // page load returns register value
    .overrideData    (specialRdData),
    .dmemValid       (cpDmemValid),
    .dmemWriteEnable (cpDmemWriteEnable),
    .dmemReadEnable  (cpDmemReadEnable),
    .dmemAddr        (cpDmemAddr),
    .dmemByteSelect  (cpDmemByteSelect),
    .dmemWriteData   (cpDmemWriteData),
    .dmemReadData    (cpDmemReadData),
    .loadData        (cpLoadData)
  );

  // ==============================
  // PE lanes
  // ==============================
  for (genvar i = 0; i < NUM_PE; i++) begin : g_pe
    dmemPort #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_pePort (
      .iClk            (iClk),
      .rstN            (rstN),
      .req             (peReq[i]),
      .overrideEn      (1'b0),          // no special page on PE lanes
      .overrideData    ('0),
      .dmemValid       (peDmemValid[i]),
      .dmemWriteEnable (peDmemWriteEnable[i]),
      .dmemReadEnable  (peDmemReadEnable[i]),
      .dmemAddr        (peDmemAddr[i]),
      .dmemByteSelect  (peDmemByteSelect[i]),
      .dmemWriteData   (peDmemWriteData[i]),
      .dmemReadData    (peDmemReadData[i]),
      .loadData        (peLoadData[i])
    );
  end

endmodule

`default_nettype wire

// ==== hdl/specialRegCtrl.sv ====
/*
  Decoder for the CP special-register page (top 256 bytes of the address space).
  Holds the two boundary-mode registers, blocks page writes from memory and
  supplies the read-back word that replaces memory data on a page load.
*/
`timescale 1ns/1ps
`default_nettype none

module specialRegCtrl import memBridgePkg::*; (
  input  wire logic                   iClk,
  input  wire logic                   rstN,
  input  wire dmemReqT                cpReq,             // raw CP request
  output dmemReqT                     gatedReq,          // to the CP memory port
  output logic                        specialRdSel,      // load in flight hit the page
  output logic [DATA_WIDTH-1:0]       specialRdData,     // read-back word
  output boundaryModeT                boundaryModeFirst, // to first PE
  output boundaryModeT                boundaryModeLast   // to last PE
);

  cpAddrU                  addrView;
  logic                    specialHit;  // request targets the special page
  logic                    specialWr;
  logic                    specialRd;
  logic [DATA_WIDTH-1:0]   rdDataQ;

  // ==============================
  // page decode
  // ==============================
  assign addrView   = cpReq.byteAddr;
  assign specialHit = &addrView.special.page;         // 0xFFFF_FFxx
  assign specialWr  = specialHit & cpReq.writeEnable;
  assign specialRd  = specialHit & cpReq.readEnable;

  // page writes never reach memory
  always_comb begin
    gatedReq             = cpReq;
    gatedReq.writeEnable = cpReq.writeEnable & ~specialHit;
  end

  // ==============================
  // boundary-mode registers
  // ==============================
  always_ff @(posedge iClk or negedge rstN) begin
    if (!rstN) begin
      boundaryModeFirst <= BOUNDARY_ZERO;
      boundaryModeLast  <= BOUNDARY_ZERO;
    end else if (specialWr) begin
      // only the low two store bits carry the mode
      if (addrView.special.regOffset == BOUNDARY_FIRST_OFFSET) begin
        boundaryModeFirst <= boundaryModeT'(cpReq.storeData[1:0]);
      end
      if (addrView.special.regOffset == BOUNDARY_LAST_OFFSET) begin
        boundaryModeLast <= boundaryModeT'(cpReq.storeData[1:0]);
      end
    end
  end

  // ==============================
  // read-back path
  // ==============================
  // select follows every CP read, so a memory load clears it again
  always_ff @(posedge iClk or negedge rstN) begin
    if (!rstN) begin
      specialRdSel <= 1'b0;
    end else if (cpReq.readEnable) begin
      specialRdSel <= specialHit;
    end
  end

  // sampled at the read edge, shown one cycle later
  always_ff @(posedge iClk) begin
    if (specialRd) begin
      if (addrView.special.regOffset == BOUNDARY_FIRST_OFFSET) begin
        rdDataQ <= {{(DATA_WIDTH-2){1'b0}}, boundaryModeFirst};
      end else begin
        rdDataQ <= {{(DATA_WIDTH-2){1'b0}}, boundaryModeLast}; // any other offset
      end
    end
  end

  assign specialRdData = rdDataQ;

endmodule

`default_nettype wire

// ==== project.f ====
hdl/memBridgePkg.sv
hdl/dmemPort.sv
hdl/specialRegCtrl.sv
hdl/simdMemBridge.sv
verification/tbClockGen.sv
verification/simdMemBridgeTb.sv

// ==== verification/simdMemBridgeTb.sv ====
/*
  Testbench for the SIMD data-memory bridge. Drives CP and PE requests,
  models one synchronous RAM per lane and checks every load one cycle later
  against a reference alignment function.
*/
`timescale 1ns/1ps
`default_nettype none

module simdMemBridgeTb import memBridgePkg::*; ();

  localparam int NUM_PE    = 4;
  localparam int ADDR_BITS = 10;
  localparam int LANES     = NUM_PE + 1;   // lane 0 is the CP
  localparam int WAIT_MAX  = 100;          // cycles per wait loop

  logic                 iClk;
  logic                 rstN;
  dmemReqT              cpReq;
  dmemReqT              peReq[NUM_PE];
  logic                 cpValid;
  logic                 cpWe;
  logic                 cpRe;
  logic                 peValid[NUM_PE];
  logic                 peWe[NUM_PE];
  logic                 peRe[NUM_PE];
  logic [ADDR_BITS-1:0] cpAddr;
  logic [ADDR_BITS-1:0] peAddr[NUM_PE];
  logic [3:0]           cpBs;
  logic [3:0]           peBs[NUM_PE];
  logic [31:0]          cpWd;
  logic [31:0]          peWd[NUM_PE];
  logic [31:0]          cpRd;
  logic [31:0]          peRd[NUM_PE];
  logic [31:0]          cpLoad;
  logic [31:0]          peLoad[NUM_PE];
  boundaryModeT         modeFirst;
  boundaryModeT         modeLast;

  // lane-indexed views with the CP as lane 0
  logic                 laneRe[LANES];
  logic                 laneWe[LANES];
  logic                 readSeen[LANES];
  logic [ADDR_BITS-1:0] laneAddr[LANES];
  logic [3:0]           laneBs[LANES];
  logic [31:0]          laneWd[LANES];
  logic [31:0]          laneLoad[LANES];
  logic [31:0]          rdData[LANES];
  logic [31:0]          mem[LANES][2**ADDR_BITS];   // memory model
  logic [31:0]          expQ[LANES][$];             // expected loads in flight

  integer       seed = 32'h2c294be7;
  int           errorCount = 0;
  int           testStart = 0;
  int           testCount = 0;
  int           testFails = 0;
  boundaryModeT expFirst = BOUNDARY_ZERO;
  boundaryModeT expLast = BOUNDARY_ZERO;

  tbClockGen u_clk (.iClk(iClk), .rstN(rstN));

  simdMemBridge #(.NUM_PE(NUM_PE), .RAM_ADDR_BITS(ADDR_BITS)) u_dut (
    .iClk(iClk), .rstN(rstN),
    .cpReq(cpReq), .cpDmemValid(cpValid), .cpDmemWriteEnable(cpWe),
    .cpDmemReadEnable(cpRe), .cpDmemAddr(cpAddr), .cpDmemByteSelect(cpBs),
    .cpDmemWriteData(cpWd), .cpDmemReadData(cpRd), .cpLoadData(cpLoad),
    .peReq(peReq), .peDmemValid(peValid), .peDmemWriteEnable(peWe),
    .peDmemReadEnable(peRe), .peDmemAddr(peAddr), .peDmemByteSelect(peBs),
    .peDmemWriteData(peWd), .peDmemReadData(peRd), .peLoadData(peLoad),
    .boundaryModeFirst(modeFirst), .boundaryModeLast(modeLast)
  );

  always_comb begin
    laneRe[0]   = cpRe;
    laneWe[0]   = cpWe;
    laneAddr[0] = cpAddr;
    laneBs[0]   = cpBs;
    laneWd[0]   = cpWd;
    laneLoad[0] = cpLoad;
    cpRd        = rdData[0];
    for (int i = 0; i < NUM_PE; i++) begin
      laneRe[i+1]   = peRe[i];
      laneWe[i+1]   = peWe[i];
      laneAddr[i+1] = peAddr[i];
      laneBs[i+1]   = peBs[i];
      laneWd[i+1]   = peWd[i];
      laneLoad[i+1] = peLoad[i];
      peRd[i]       = rdData[i+1];
    end
  end

  // ==============================
  // memory model and compare
  // ==============================
  initial begin
    for (int l = 0; l < LANES; l++) begin
      rdData[l] <= '0;
      for (int a = 0; a < 2**ADDR_BITS; a++) begin
        mem[l][a] <= (a * 32'h9e3779b1) ^ {l[7:0], 14'h0, a[9:0]}; // whole-address fill
      end
    end
  end

  always @(posedge iClk) begin
    for (int l = 0; l < LANES; l++) begin
      readSeen[l] <= laneRe[l];
      if (laneRe[l]) rdData[l] <= mem[l][laneAddr[l]];  // one-cycle latency
      for (int b = 0; b < 4; b++) begin
        if (laneWe[l] && laneBs[l][b]) mem[l][laneAddr[l]][8*b +: 8] <= laneWd[l][8*b +: 8];
      end
    end
  end

  // load result is stable by the falling edge
  always @(negedge iClk) begin
    if (rstN) begin
      for (int l = 0; l < LANES; l++) begin
        if (readSeen[l]) begin
          if (expQ[l].size() == 0) begin
            $display("lane %0d returned a load that was never requested", l);
            errorCount++;
          end else begin
            checkValue($sformatf("loadData[lane %0d]", l), expQ[l].pop_front(), laneLoad[l]);
          end
        end
      end
    end
  end

  // reference alignment gives right-aligned zero-extended data
  function automatic logic [31:0] alignLoad(lsuOpT op, logic [1:0] offset, logic [31:0] word);
    logic [31:0] res;
    case (op)
      LSU_HALF: res = offset[1] ? {16'h0, word[31:16]} : {16'h0, word[15:0]};
      LSU_BYTE: res = {24'h0, word[8*offset +: 8]};
      default:  res = word;
    endcase
    return res;
  endfunction

  task automatic checkValue(string name, logic [31:0] exp, logic [31:0] got);
    assert (exp === got) else begin
      $display("FAILED t=%0t %s expected=%h actual=%h", $time, name, exp, got);
      errorCount++;
    end
  endtask

  task automatic tick();
    @(posedge iClk);
    #1;
  endtask

  task automatic idleAll();
    cpReq = '0;
    for (int i = 0; i < NUM_PE; i++) peReq[i] = '0;
  endtask

  function automatic lsuOpT randomOp();
    int r;
    r = $random(seed) & 3;
    return (r == 3) ? LSU_WORD : lsuOpT'(r);
  endfunction

  task automatic waitDrain();
    int n = 0;
    int busy = 1;
    while (busy && n < WAIT_MAX) begin
      @(posedge iClk);
      n++;
      busy = 0;
      for (int l = 0; l < LANES; l++) if (expQ[l].size() != 0) busy = 1;
    end
    #1;
    if (busy) begin
      $display("timeout: loads still outstanding after %0d cycles", WAIT_MAX);
      errorCount++;
    end
  endtask

  task automatic endTest(string name);
    idleAll();
    waitDrain();
    testCount++;
    if (errorCount == testStart) $display("test %0s passed", name);
    else begin
      $display("test %0s failed with %0d errors", name, errorCount - testStart);
      testFails++;
    end
    testStart = errorCount;
  endtask

  // ==============================
  // stimulus
  // ==============================
  initial begin
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  bs;
    lsuOpT       op;
    int          n;
    idleAll();
    n = 0;
    while (rstN !== 1'b1 && n < WAIT_MAX) begin
      @(posedge iClk);
      n++;
    end
    if (rstN !== 1'b1) begin
      $display("timeout: reset never released");
      errorCount++;
    end
    tick();

    // after reset
    checkValue("boundaryModeFirst", 32'(BOUNDARY_ZERO), 32'(modeFirst));
    checkValue("boundaryModeLast", 32'(BOUNDARY_ZERO), 32'(modeLast));
    for (int l = 0; l < LANES; l++) begin
      checkValue($sformatf("dmemWriteEnable[lane %0d]", l), 0, 32'(laneWe[l]));
    end
    checkValue("cpDmemValid", 0, 32'(cpValid));
    for (int i = 0; i < NUM_PE; i++) checkValue("peDmemValid", 0, 32'(peValid[i]));
    endTest("reset");

    // back-to-back CP loads then one store
    for (int k = 0; k < 24; k++) begin
      addr = $random(seed);
      if (&addr[31:8]) addr[31] = 1'b0;         // stay off the special page
      op = randomOp();
      cpReq = '0;
      cpReq.readEnable = 1'b1;
      cpReq.opcode = op;
      cpReq.byteAddr = addr;
      expQ[0].push_back(alignLoad(op, addr[1:0], mem[0][addr[11:2]]));
      #2 checkValue("cpDmemAddr", 32'(addr[11:2]), 32'(cpAddr));
      checkValue("cpDmemValid", 1, 32'(cpValid));
      tick();
    end
    addr = $random(seed) & 32'h0000_0ffc;
    data = $random(seed);
    bs = 4'($random(seed));
    cpReq = '0;
    cpReq.writeEnable = 1'b1;
    cpReq.byteAddr = addr;
    cpReq.byteSelect = bs;
    cpReq.storeData = data;
    #2 checkValue("cpDmemWriteEnable", 1, 32'(cpWe));
    checkValue("cpDmemValid", 1, 32'(cpValid));
    checkValue("cpDmemAddr", 32'(addr[11:2]), 32'(cpAddr));
    checkValue("cpDmemByteSelect", 32'(bs), 32'(cpBs));
    checkValue("cpDmemWriteData", data, cpWd);
    tick();
    endTest("cp loads");

    // PE lanes load together before each stores once
    for (int k = 0; k < 12; k++) begin
      for (int i = 0; i < NUM_PE; i++) begin
        addr = $random(seed) & 32'h0000_0fff;
        op = randomOp();
        peReq[i] = '0;
        peReq[i].readEnable = 1'b1;
        peReq[i].opcode = op;
        peReq[i].byteAddr = addr;
        expQ[i+1].push_back(alignLoad(op, addr[1:0], mem[i+1][addr[11:2]]));
      end
      #2;
      for (int i = 0; i < NUM_PE; i++) begin
        checkValue($sformatf("peDmemValid[%0d]", i), 1, 32'(peValid[i]));
      end
      tick();
    end
    idleAll();
    for (int i = 0; i < NUM_PE; i++) begin
      addr = ($random(seed) & 32'h0000_0ffc);
      data = $random(seed);
      peReq[i].writeEnable = 1'b1;
      peReq[i].byteAddr = addr;
      peReq[i].byteSelect = 4'hf;
      peReq[i].storeData = data;
      #2 checkValue("peDmemValid", 1, 32'(peValid[i]));
      checkValue("peDmemWriteEnable", 1, 32'(peWe[i]));
      tick();
      checkValue("model word", data, mem[i+1][addr[11:2]]);
      peReq[i] = '0;
    end
    endTest("pe lanes");

    // special-page writes never reach memory
    for (int k = 0; k < 6; k++) begin
      data = $random(seed);
      if (k == 5) data[1:0] = ~expFirst;        // keep the two modes apart for read-back
      cpReq = '0;
      cpReq.writeEnable = 1'b1;
      cpReq.byteAddr = (k % 2) ? 32'hffff_ff04 : 32'hffff_ff00;
      cpReq.byteSelect = 4'hf;
      cpReq.storeData = data;
      #2 checkValue("cpDmemWriteEnable", 0, 32'(cpWe));
      checkValue("cpDmemValid", 0, 32'(cpValid));
      if (k % 2) expLast = boundaryModeT'(data[1:0]);
      else expFirst = boundaryModeT'(data[1:0]);
      tick();
      checkValue("boundaryModeFirst", 32'(expFirst), 32'(modeFirst));
      checkValue("boundaryModeLast", 32'(expLast), 32'(modeLast));
    end
    endTest("special write");

    // read-back where other offsets map to the last mode
    for (int k = 0; k < 6; k++) begin
      cpReq = '0;
      cpReq.readEnable = 1'b1;
      cpReq.byteAddr = 32'hffff_ff00 | ((k == 0) ? 0 : (k * 4 + ($random(seed) & 32'hc0)));
      expQ[0].push_back((k == 0) ? {30'h0, expFirst} : {30'h0, expLast});
      tick();
    end
    // a plain load afterwards returns memory data again
    addr = $random(seed) & 32'h0000_0fff;
    cpReq = '0;
    cpReq.readEnable = 1'b1;
    cpReq.opcode = LSU_WORD;
    cpReq.byteAddr = addr;
    expQ[0].push_back(alignLoad(LSU_WORD, addr[1:0], mem[0][addr[11:2]]));
    tick();
    endTest("special read");

    $display("%0d tests, %0d failed, %0d errors", testCount, testFails, errorCount);
    if (errorCount == 0) $display("Test OK");
    else $display("Test FAILED");
    $finish;
  end

  // watchdog against a hung run
  initial begin
    #200us;
    $display("timeout: simulation did not finish");
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/tbClockGen.sv ====
/*
  Testbench clock and reset source.
  20 ns clock, rstN held low for the first 4 rising edges.
*/
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
  parameter realtime PERIOD      = 20ns,
  parameter int      RESET_TICKS = 4
) (
  output logic iClk,
  output logic rstN
);

  initial begin
    iClk = 1'b0;
    forever #(PERIOD / 2) iClk = ~iClk;
  end

  initial begin
    rstN = 1'b0;                          // asserted from time zero
    repeat (RESET_TICKS) @(posedge iClk);
    #1 rstN = 1'b1;                       // release off the edge
  end

endmodule

`default_nettype wire
